// File: hdl/mmio_pkg.sv
// Shared sizes, address layout and request opcodes for the MMIO host channel.
// Every design file refers to these by scoped name, so the package must be
// compiled before any module that uses it.

package mmio_pkg;

    // Number of register banks behind the decoder
    localparam int NUM_BANKS = 4;

    // Number of 64-bit registers in each bank
    localparam int REGS_PER_BANK = 8;

    // Read tags available to the host, which is also the depth of each bank FIFO
    localparam int MAX_OUTSTANDING = 16;

    // Width of a read tag
    localparam int TAG_BITS = 4;

    // Width of the byte address coming from the host
    localparam int ADDR_BITS = 10;

    // Register and payload width
    localparam int DATA_BITS = 64;

    // Completion header fields echoed from the request
    localparam int REQ_ID_BITS = 16;
    localparam int TC_BITS = 3;

    // Byte count is 4 or 8, so the length in dwords is 1 or 2
    localparam int BCOUNT_BITS = 4;
    localparam int LENGTH_BITS = BCOUNT_BITS - 2;

    // Completions carry the low 7 bits of the request address
    localparam int LOWER_ADDR_BITS = 7;

    // Derived index widths
    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int REG_BITS = $clog2(REGS_PER_BANK);

    // Address layout: bits 9:8 pick the bank, bits 5:3 the register
    // and bit 2 the 32-bit lane inside the register
    localparam int BANK_LSB = 8;
    localparam int REG_LSB = 3;
    localparam int LANE_BIT = 2;

    // Request opcode as driven by the host
    typedef enum logic
    {
        MMIO_OP_READ  = 1'b0,
        MMIO_OP_WRITE = 1'b1
    } mmio_op_t;

endpackage

// File: hdl/mmio_req_decoder.sv
// Host request decoder. Registers each request strobe once and splits the
// address into bank select, register index and lane. Read details go to
// the completion generator so the completion can be built later.

`timescale 1ns/1ns

module mmio_req_decoder
(
    input  logic clk,
    input  logic reset_n,

    // Host requests, always accepted
    input  logic req_valid,
    input  mmio_pkg::mmio_op_t req_op,
    input  logic [mmio_pkg::TAG_BITS-1:0] req_tag,
    input  logic [mmio_pkg::ADDR_BITS-1:0] req_addr,
    input  logic [mmio_pkg::BCOUNT_BITS-1:0] req_byte_count,
    input  logic [mmio_pkg::REQ_ID_BITS-1:0] req_requester_id,
    input  logic [mmio_pkg::TC_BITS-1:0] req_tc,
    input  logic [mmio_pkg::DATA_BITS-1:0] req_wdata,

    // Shared request bus to every bank
    output logic bank_valid,
    output logic [mmio_pkg::NUM_BANKS-1:0] bank_sel,
    output mmio_pkg::mmio_op_t bank_op,
    output logic [mmio_pkg::REG_BITS-1:0] bank_reg,
    output logic bank_lane,
    output logic [mmio_pkg::TAG_BITS-1:0] bank_tag,
    output logic [mmio_pkg::DATA_BITS-1:0] bank_wdata,

    // Read details for the outstanding-read table
    output logic meta_wen,
    output logic [mmio_pkg::TAG_BITS-1:0] meta_tag,
    output logic [mmio_pkg::BCOUNT_BITS-1:0] meta_byte_count,
    output logic [mmio_pkg::REQ_ID_BITS-1:0] meta_requester_id,
    output logic [mmio_pkg::TC_BITS-1:0] meta_tc,
    output logic [mmio_pkg::LOWER_ADDR_BITS-1:0] meta_lower_addr
);

    logic [mmio_pkg::NUM_BANKS-1:0] sel_next;

    // One-hot bank select from the upper address bits
    always_comb
    begin
        sel_next = '0;
        sel_next[req_addr[mmio_pkg::BANK_LSB +: mmio_pkg::BANK_BITS]] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        // Payload fields follow the request every cycle and are only
        // looked at when the matching valid is high
        bank_valid <= req_valid;
        bank_sel <= sel_next;
        bank_op <= req_op;
        bank_reg <= req_addr[mmio_pkg::REG_LSB +: mmio_pkg::REG_BITS];
        bank_lane <= req_addr[mmio_pkg::LANE_BIT];
        bank_tag <= req_tag;
        bank_wdata <= req_wdata;

        // Only reads need a completion, so only reads fill the table
        meta_wen <= req_valid && (req_op == mmio_pkg::MMIO_OP_READ);
        meta_tag <= req_tag;
        meta_byte_count <= req_byte_count;
        meta_requester_id <= req_requester_id;
        meta_tc <= req_tc;
        meta_lower_addr <= req_addr[mmio_pkg::LOWER_ADDR_BITS-1:0];

        if (!reset_n)
        begin
            bank_valid <= 1'b0;
            meta_wen <= 1'b0;
        end
    end

endmodule

// File: hdl/mmio_csr_bank.sv
// One bank of eight 64-bit registers. Writes update a whole register and
// reads push tag and data into the bank's own response FIFO, which the
// response arbiter drains with a valid/ready handshake.

`timescale 1ns/1ns

module mmio_csr_bank
(
    input  logic clk,
    input  logic reset_n,

    // Request bus from the decoder, shared by all banks
    input  logic bank_valid,
    input  logic bank_sel,
    input  mmio_pkg::mmio_op_t bank_op,
    input  logic [mmio_pkg::REG_BITS-1:0] bank_reg,
    input  logic bank_lane,
    input  logic [mmio_pkg::TAG_BITS-1:0] bank_tag,
    input  logic [mmio_pkg::DATA_BITS-1:0] bank_wdata,

    // Response FIFO head toward the arbiter
    input  logic rsp_ready,
    output logic rsp_valid,
    output logic [mmio_pkg::TAG_BITS-1:0] rsp_tag,
    output logic [mmio_pkg::DATA_BITS-1:0] rsp_data
);

    logic [mmio_pkg::DATA_BITS-1:0] regs [mmio_pkg::REGS_PER_BANK];

    // FIFO depth equals the tag space, so the pointers are tag wide
    logic [mmio_pkg::TAG_BITS-1:0] fifo_tag [mmio_pkg::MAX_OUTSTANDING];
    logic [mmio_pkg::DATA_BITS-1:0] fifo_data [mmio_pkg::MAX_OUTSTANDING];
    logic [mmio_pkg::TAG_BITS-1:0] wr_ptr;
    logic [mmio_pkg::TAG_BITS-1:0] rd_ptr;
    logic [mmio_pkg::TAG_BITS:0] count;

    logic wr_en;
    logic push;
    logic pop;
    logic [mmio_pkg::DATA_BITS-1:0] rd_reg;
    logic [mmio_pkg::DATA_BITS-1:0] rd_data;

    assign wr_en = bank_valid && bank_sel && (bank_op == mmio_pkg::MMIO_OP_WRITE);
    assign push = bank_valid && bank_sel && (bank_op == mmio_pkg::MMIO_OP_READ);
    assign pop = rsp_valid && rsp_ready;

    // Lane 1 returns the upper half in the low bits with the top zeroed
    assign rd_reg = regs[bank_reg];
    assign rd_data = bank_lane ?
        {{(mmio_pkg::DATA_BITS/2){1'b0}},
         rd_reg[mmio_pkg::DATA_BITS-1:mmio_pkg::DATA_BITS/2]} :
        rd_reg;

    // Register file, cleared by reset as the host expects zeros after reset
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            regs[bank_reg] <= bank_wdata;
        end

        if (!reset_n)
        begin
            regs <= '{default: '0};
        end
    end

    // FIFO storage needs no reset since count guards every read
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_tag[wr_ptr] <= bank_tag;
            fifo_data[wr_ptr] <= rd_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            wr_ptr <= wr_ptr + 1;
        end
        if (pop)
        begin
            rd_ptr <= rd_ptr + 1;
        end

        // At most MAX_OUTSTANDING reads exist, so a push never finds it full
        case ({push, pop})
            2'b10: count <= count + 1;
            2'b01: count <= count - 1;
            default: count <= count;
        endcase

        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

    assign rsp_valid = (count != '0);
    assign rsp_tag = fifo_tag[rd_ptr];
    assign rsp_data = fifo_data[rd_ptr];

endmodule

// File: hdl/mmio_rsp_arbiter.sv
// Round-robin arbiter over the bank response FIFO heads. The search starts
// at the bank after the last grant, the winner is passed on combinationally
// and only the winning bank sees ready.

`timescale 1ns/1ns

module mmio_rsp_arbiter
(
    input  logic clk,
    input  logic reset_n,

    // FIFO heads of all banks
    input  logic [mmio_pkg::NUM_BANKS-1:0] rsp_valid,
    input  logic [mmio_pkg::NUM_BANKS-1:0][mmio_pkg::TAG_BITS-1:0] rsp_tag,
    input  logic [mmio_pkg::NUM_BANKS-1:0][mmio_pkg::DATA_BITS-1:0] rsp_data,
    output logic [mmio_pkg::NUM_BANKS-1:0] rsp_ready,

    // Selected response toward the completion generator
    input  logic afu_ready,
    output logic afu_valid,
    output logic [mmio_pkg::TAG_BITS-1:0] afu_tag,
    output logic [mmio_pkg::DATA_BITS-1:0] afu_data
);

    logic [mmio_pkg::BANK_BITS-1:0] last_grant;
    logic [mmio_pkg::BANK_BITS-1:0] grant;
    logic found;

    // Walk the banks once, beginning right after the previous winner.
    // The last step lands on the previous winner itself
    always_comb
    begin
        logic [mmio_pkg::BANK_BITS:0] i;
        logic [mmio_pkg::BANK_BITS-1:0] cand;

        found = 1'b0;
        grant = last_grant;
        for (i = 1; i <= mmio_pkg::NUM_BANKS; i++)
        begin
            cand = last_grant + i[mmio_pkg::BANK_BITS-1:0];
            if (!found && rsp_valid[cand])
            begin
                found = 1'b1;
                grant = cand;
            end
        end
    end

    assign afu_valid = found;
    assign afu_tag = rsp_tag[grant];
    assign afu_data = rsp_data[grant];

    // Ready goes back to the granted bank only
    always_comb
    begin
        rsp_ready = '0;
        rsp_ready[grant] = found && afu_ready;
    end

    // The pointer moves only when a response is actually taken
    always_ff @(posedge clk)
    begin
        if (afu_valid && afu_ready)
        begin
            last_grant <= grant;
        end

        // Starting at the top makes bank 0 the first candidate
        if (!reset_n)
        begin
            last_grant <= '1;
        end
    end

endmodule

// File: hdl/mmio_cpl_gen.sv
// Completion generator. Keeps the details of each outstanding read by tag,
// joins them with the bank response and drives completions with data out of
// an output register under a valid/ready handshake.

`timescale 1ns/1ns

module mmio_cpl_gen
(
    input  logic clk,
    input  logic reset_n,

    // Read details written by the decoder
    input  logic meta_wen,
    input  logic [mmio_pkg::TAG_BITS-1:0] meta_tag,
    input  logic [mmio_pkg::BCOUNT_BITS-1:0] meta_byte_count,
    input  logic [mmio_pkg::REQ_ID_BITS-1:0] meta_requester_id,
    input  logic [mmio_pkg::TC_BITS-1:0] meta_tc,
    input  logic [mmio_pkg::LOWER_ADDR_BITS-1:0] meta_lower_addr,

    // Responses from the arbiter
    input  logic afu_valid,
    input  logic [mmio_pkg::TAG_BITS-1:0] afu_tag,
    input  logic [mmio_pkg::DATA_BITS-1:0] afu_data,
    output logic afu_ready,

    // Completion with data
    input  logic cpl_ready,
    output logic cpl_valid,
    output logic [mmio_pkg::TAG_BITS-1:0] cpl_tag,
    output logic [mmio_pkg::LENGTH_BITS-1:0] cpl_length,
    output logic [mmio_pkg::BCOUNT_BITS-1:0] cpl_byte_count,
    output logic [mmio_pkg::REQ_ID_BITS-1:0] cpl_requester_id,
    output logic [mmio_pkg::TC_BITS-1:0] cpl_tc,
    output logic [mmio_pkg::LOWER_ADDR_BITS-1:0] cpl_lower_addr,
    output logic [mmio_pkg::DATA_BITS-1:0] cpl_data
);

    // Outstanding-read table, one entry per tag
    logic [mmio_pkg::BCOUNT_BITS-1:0] tbl_byte_count [mmio_pkg::MAX_OUTSTANDING];
    logic [mmio_pkg::REQ_ID_BITS-1:0] tbl_requester_id [mmio_pkg::MAX_OUTSTANDING];
    logic [mmio_pkg::TC_BITS-1:0] tbl_tc [mmio_pkg::MAX_OUTSTANDING];
    logic [mmio_pkg::LOWER_ADDR_BITS-1:0] tbl_lower_addr [mmio_pkg::MAX_OUTSTANDING];

    // Two-entry FIFO holding the joined response and details
    logic [mmio_pkg::TAG_BITS-1:0] fifo_tag [2];
    logic [mmio_pkg::DATA_BITS-1:0] fifo_data [2];
    logic [mmio_pkg::BCOUNT_BITS-1:0] fifo_byte_count [2];
    logic [mmio_pkg::REQ_ID_BITS-1:0] fifo_requester_id [2];
    logic [mmio_pkg::TC_BITS-1:0] fifo_tc [2];
    logic [mmio_pkg::LOWER_ADDR_BITS-1:0] fifo_lower_addr [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] fifo_count;

    logic push;
    logic deq;
    logic not_empty;
    logic out_free;

    // The table entry is always written before the response can arrive
    always_ff @(posedge clk)
    begin
        if (meta_wen)
        begin
            tbl_byte_count[meta_tag] <= meta_byte_count;
            tbl_requester_id[meta_tag] <= meta_requester_id;
            tbl_tc[meta_tag] <= meta_tc;
            tbl_lower_addr[meta_tag] <= meta_lower_addr;
        end
    end

    // Back-pressure to the arbiter is simply FIFO not full
    assign afu_ready = (fifo_count != 2'd2);
    assign push = afu_valid && afu_ready;
    assign not_empty = (fifo_count != 2'd0);

    // The output register can load when empty or when its data is taken
    assign out_free = cpl_ready || !cpl_valid;
    assign deq = not_empty && out_free;

    // Joined entry, looked up by the tag of the incoming response
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_tag[wr_ptr] <= afu_tag;
            fifo_data[wr_ptr] <= afu_data;
            fifo_byte_count[wr_ptr] <= tbl_byte_count[afu_tag];
            fifo_requester_id[wr_ptr] <= tbl_requester_id[afu_tag];
            fifo_tc[wr_ptr] <= tbl_tc[afu_tag];
            fifo_lower_addr[wr_ptr] <= tbl_lower_addr[afu_tag];
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            wr_ptr <= !wr_ptr;
        end
        if (deq)
        begin
            rd_ptr <= !rd_ptr;
        end

        case ({push, deq})
            2'b10: fifo_count <= fifo_count + 2'd1;
            2'b01: fifo_count <= fifo_count - 2'd1;
            default: fifo_count <= fifo_count;
        endcase

        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            fifo_count <= 2'd0;
        end
    end

    // Output register. Fields hold while a completion waits for cpl_ready
    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            cpl_valid <= not_empty;
            cpl_tag <= fifo_tag[rd_ptr];
            cpl_data <= fifo_data[rd_ptr];
            // Length in dwords is the byte count divided by four
            cpl_length <= fifo_byte_count[rd_ptr][mmio_pkg::BCOUNT_BITS-1:2];
            cpl_byte_count <= fifo_byte_count[rd_ptr];
            cpl_requester_id <= fifo_requester_id[rd_ptr];
            cpl_tc <= fifo_tc[rd_ptr];
            cpl_lower_addr <= fifo_lower_addr[rd_ptr];
        end

        if (!reset_n)
        begin
            cpl_valid <= 1'b0;
        end
    end

endmodule

// File: hdl/mmio_host_chan.sv
// Top of the MMIO host channel. Host requests enter the decoder, reach
// one of the register banks, and read responses come back through the
// arbiter and the completion generator as completions with data.

`timescale 1ns/1ns

module mmio_host_chan
(
    input  logic clk,
    input  logic reset_n,

    // Host request strobe
    input  logic req_valid,
    input  mmio_pkg::mmio_op_t req_op,
    input  logic [mmio_pkg::TAG_BITS-1:0] req_tag,
    input  logic [mmio_pkg::ADDR_BITS-1:0] req_addr,
    input  logic [mmio_pkg::BCOUNT_BITS-1:0] req_byte_count,
    input  logic [mmio_pkg::REQ_ID_BITS-1:0] req_requester_id,
    input  logic [mmio_pkg::TC_BITS-1:0] req_tc,
    input  logic [mmio_pkg::DATA_BITS-1:0] req_wdata,

    // Completion output
    input  logic cpl_ready,
    output logic cpl_valid,
    output logic [mmio_pkg::TAG_BITS-1:0] cpl_tag,
    output logic [mmio_pkg::LENGTH_BITS-1:0] cpl_length,
    output logic [mmio_pkg::BCOUNT_BITS-1:0] cpl_byte_count,
    output logic [mmio_pkg::REQ_ID_BITS-1:0] cpl_requester_id,
    output logic [mmio_pkg::TC_BITS-1:0] cpl_tc,
    output logic [mmio_pkg::LOWER_ADDR_BITS-1:0] cpl_lower_addr,
    output logic [mmio_pkg::DATA_BITS-1:0] cpl_data
);

    // Decoder to banks
    logic bank_valid;
    logic [mmio_pkg::NUM_BANKS-1:0] bank_sel;
    mmio_pkg::mmio_op_t bank_op;
    logic [mmio_pkg::REG_BITS-1:0] bank_reg;
    logic bank_lane;
    logic [mmio_pkg::TAG_BITS-1:0] bank_tag;
    logic [mmio_pkg::DATA_BITS-1:0] bank_wdata;

    // Decoder to completion generator
    logic meta_wen;
    logic [mmio_pkg::TAG_BITS-1:0] meta_tag;
    logic [mmio_pkg::BCOUNT_BITS-1:0] meta_byte_count;
    logic [mmio_pkg::REQ_ID_BITS-1:0] meta_requester_id;
    logic [mmio_pkg::TC_BITS-1:0] meta_tc;
    logic [mmio_pkg::LOWER_ADDR_BITS-1:0] meta_lower_addr;

    // Bank FIFO heads and the arbiter output
    logic [mmio_pkg::NUM_BANKS-1:0] rsp_valid;
    logic [mmio_pkg::NUM_BANKS-1:0] rsp_ready;
    logic [mmio_pkg::NUM_BANKS-1:0][mmio_pkg::TAG_BITS-1:0] rsp_tag;
    logic [mmio_pkg::NUM_BANKS-1:0][mmio_pkg::DATA_BITS-1:0] rsp_data;
    logic afu_valid;
    logic afu_ready;
    logic [mmio_pkg::TAG_BITS-1:0] afu_tag;
    logic [mmio_pkg::DATA_BITS-1:0] afu_data;

    mmio_req_decoder i_decoder
    (
        .clk, .reset_n,
        .req_valid, .req_op, .req_tag, .req_addr,
        .req_byte_count, .req_requester_id, .req_tc, .req_wdata,
        .bank_valid, .bank_sel, .bank_op, .bank_reg,
        .bank_lane, .bank_tag, .bank_wdata,
        .meta_wen, .meta_tag, .meta_byte_count,
        .meta_requester_id, .meta_tc, .meta_lower_addr
    );

    // The request bus fans out to every bank; bank_sel picks the one that acts
    for (genvar b = 0; b < mmio_pkg::NUM_BANKS; b++)
    begin : g_bank
        mmio_csr_bank i_bank
        (
            .clk, .reset_n,
            .bank_valid, .bank_sel(bank_sel[b]), .bank_op, .bank_reg,
            .bank_lane, .bank_tag, .bank_wdata,
            .rsp_ready(rsp_ready[b]),
            .rsp_valid(rsp_valid[b]),
            .rsp_tag(rsp_tag[b]),
            .rsp_data(rsp_data[b])
        );
    end

    mmio_rsp_arbiter i_arbiter
    (
        .clk, .reset_n,
        .rsp_valid, .rsp_tag, .rsp_data, .rsp_ready,
        .afu_ready, .afu_valid, .afu_tag, .afu_data
    );

    mmio_cpl_gen i_cpl_gen
    (
        .clk, .reset_n,
        .meta_wen, .meta_tag, .meta_byte_count,
        .meta_requester_id, .meta_tc, .meta_lower_addr,
        .afu_valid, .afu_tag, .afu_data, .afu_ready,
        .cpl_ready, .cpl_valid, .cpl_tag, .cpl_length, .cpl_byte_count,
        .cpl_requester_id, .cpl_tc, .cpl_lower_addr, .cpl_data
    );

endmodule

// File: verification/mmio_host_chan_tb.sv
// Testbench for the MMIO host channel. Drives reads and writes as host
// strobes, predicts each completion from a register model at issue time and
// checks every completion handshake against the prediction kept for its tag.

`timescale 1ns/1ns

module mmio_host_chan_tb;

    // Request counts of the five tests, which also size the watchdog
    localparam int ZERO_READS = 32;
    localparam int WR_RD_REQS = 8;
    localparam int LANE_REQS = 12;
    localparam int BURST_READS = 16;
    localparam int MIX_REQS = 400;
    localparam int TOTAL_REQS = ZERO_READS + WR_RD_REQS + LANE_REQS + BURST_READS + MIX_REQS;
    localparam logic [31:0] SEED = 32'hddd5;

    // Everything a completion is expected to carry
    typedef struct packed {
        logic [63:0] data;
        logic [1:0] length;
        logic [3:0] byte_count;
        logic [15:0] requester_id;
        logic [2:0] tc;
        logic [6:0] lower_addr;
    } cpl_t;

    logic clk;
    logic reset_n;
    logic req_valid;
    mmio_pkg::mmio_op_t req_op;
    logic [mmio_pkg::TAG_BITS-1:0] req_tag;
    logic [mmio_pkg::ADDR_BITS-1:0] req_addr;
    logic [mmio_pkg::BCOUNT_BITS-1:0] req_byte_count;
    logic [mmio_pkg::REQ_ID_BITS-1:0] req_requester_id;
    logic [mmio_pkg::TC_BITS-1:0] req_tc;
    logic [mmio_pkg::DATA_BITS-1:0] req_wdata;
    logic cpl_ready;
    logic cpl_valid;
    logic [mmio_pkg::TAG_BITS-1:0] cpl_tag;
    logic [mmio_pkg::LENGTH_BITS-1:0] cpl_length;
    logic [mmio_pkg::BCOUNT_BITS-1:0] cpl_byte_count;
    logic [mmio_pkg::REQ_ID_BITS-1:0] cpl_requester_id;
    logic [mmio_pkg::TC_BITS-1:0] cpl_tc;
    logic [mmio_pkg::LOWER_ADDR_BITS-1:0] cpl_lower_addr;
    logic [mmio_pkg::DATA_BITS-1:0] cpl_data;

    // Register model and one expectation slot per tag
    logic [63:0] model [4][8];
    cpl_t exp_slot [16];
    bit slot_active [16];
    string slot_test [16];

    logic [31:0] stim_seed;
    logic [31:0] ready_seed;
    logic [3:0] next_tag;
    // 0 keeps cpl_ready high, 1 holds it low, 2 randomizes it
    logic [1:0] ready_mode;
    int checks;
    int value_errors;
    int other_errors;
    int completions;

    mmio_host_chan i_dut
    (
        .clk, .reset_n,
        .req_valid, .req_op, .req_tag, .req_addr,
        .req_byte_count, .req_requester_id, .req_tc, .req_wdata,
        .cpl_ready, .cpl_valid, .cpl_tag, .cpl_length, .cpl_byte_count,
        .cpl_requester_id, .cpl_tc, .cpl_lower_addr, .cpl_data
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // The low LCG bits repeat quickly, so only the upper halves are used
    task automatic draw_random(output logic [31:0] value);
        stim_seed = lcg_next(stim_seed);
        value[31:16] = stim_seed[31:16];
        stim_seed = lcg_next(stim_seed);
        value[15:0] = stim_seed[31:16];
    endtask

    // Completion predicted from the register model as it stands at issue
    function automatic cpl_t expected_cpl(input logic [9:0] addr, input logic [3:0] byte_count,
                                          input logic [15:0] requester_id, input logic [2:0] tc);
        cpl_t c;
        logic [63:0] value;
        logic [3:0] dwords;
        value = model[addr[9:8]][addr[5:3]];
        // Lane 1 returns the upper word moved down to the low half
        c.data = addr[2] ? {32'h0, value[63:32]} : value;
        dwords = byte_count / 4'd4;
        c.length = dwords[1:0];
        c.byte_count = byte_count;
        c.requester_id = requester_id;
        c.tc = tc;
        c.lower_addr = addr[6:0];
        return c;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
        end
    endtask

    function automatic int outstanding_count();
        int n;
        n = 0;
        for (int t = 0; t < 16; t++)
        begin
            if (slot_active[t])
            begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One request strobe, held for exactly one cycle
    task automatic drive_req(input mmio_pkg::mmio_op_t op, input logic [3:0] tag,
                             input logic [9:0] addr, input logic [3:0] byte_count,
                             input logic [15:0] requester_id, input logic [2:0] tc,
                             input logic [63:0] wdata);
        req_valid = 1'b1;
        req_op = op;
        req_tag = tag;
        req_addr = addr;
        req_byte_count = byte_count;
        req_requester_id = requester_id;
        req_tc = tc;
        req_wdata = wdata;
        idle_cycles(1);
        req_valid = 1'b0;
    endtask

    task automatic send_write(input logic [9:0] addr, input logic [63:0] wdata);
        model[addr[9:8]][addr[5:3]] = wdata;
        drive_req(mmio_pkg::MMIO_OP_WRITE, 4'd0, addr, 4'd8, 16'd0, 3'd0, wdata);
    endtask

    task automatic send_read(input logic [3:0] tag, input logic [9:0] addr,
                             input logic [3:0] byte_count, input logic [15:0] requester_id,
                             input logic [2:0] tc, input string test);
        exp_slot[tag] = expected_cpl(addr, byte_count, requester_id, tc);
        slot_test[tag] = test;
        slot_active[tag] = 1'b1;
        drive_req(mmio_pkg::MMIO_OP_READ, tag, addr, byte_count, requester_id, tc, 64'd0);
    endtask

    // Rotating search keeps the whole tag space in use; idles while all are busy
    task automatic take_free_tag(output logic [3:0] tag);
        bit found;
        logic [3:0] cand;
        found = 1'b0;
        while (!found)
        begin
            for (int n = 0; n < 16; n++)
            begin
                cand = next_tag + n[3:0];
                if (!found && !slot_active[cand])
                begin
                    found = 1'b1;
                    tag = cand;
                end
            end
            if (!found)
            begin
                idle_cycles(1);
            end
        end
        next_tag = tag + 4'd1;
    endtask

    task automatic wait_all_done();
        while (outstanding_count() != 0)
        begin
            @(posedge clk);
        end
        #1;
    endtask

    // Ready is driven with the other inputs, one step after the edge
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            ready_seed = lcg_next(ready_seed);
            case (ready_mode)
                2'd1: cpl_ready = 1'b0;
                2'd2: cpl_ready = ready_seed[31];
                default: cpl_ready = 1'b1;
            endcase
        end
    end

    // Completion monitor. Sampling at the falling edge sees valid and ready
    // exactly as the next rising edge will take them
    always @(negedge clk)
    begin
        logic [63:0] mask;
        string name;
        cpl_t e;
        if (reset_n && cpl_valid && cpl_ready)
        begin
            if (!slot_active[cpl_tag])
            begin
                other_errors++;
                $display("A completion arrived for tag %0d, which has no read outstanding",
                         cpl_tag);
            end
            else
            begin
                e = exp_slot[cpl_tag];
                name = $sformatf("%s tag %0d", slot_test[cpl_tag], cpl_tag);
                // A 4-byte read only defines the low word of the payload
                mask = (e.byte_count == 4'd4) ? 64'h0000_0000_ffff_ffff : '1;
                check_value({name, " data"}, e.data & mask, cpl_data & mask);
                check_value({name, " length"}, 64'(e.length), 64'(cpl_length));
                check_value({name, " byte count"}, 64'(e.byte_count), 64'(cpl_byte_count));
                check_value({name, " requester id"}, 64'(e.requester_id),
                            64'(cpl_requester_id));
                check_value({name, " tc"}, 64'(e.tc), 64'(cpl_tc));
                check_value({name, " lower addr"}, 64'(e.lower_addr), 64'(cpl_lower_addr));
                slot_active[cpl_tag] = 1'b0;
                completions++;
            end
        end
    end

    initial
    begin
        repeat (TOTAL_REQS * 40) @(posedge clk);
        $display("Watchdog expired with %0d reads still waiting for a completion",
                 outstanding_count());
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [3:0] tag;
        logic [9:0] addr;
        logic [3:0] bcount;
        logic [63:0] wdata;

        reset_n = 1'b0;
        req_valid = 1'b0;
        req_op = mmio_pkg::MMIO_OP_READ;
        req_tag = '0;
        req_addr = '0;
        req_byte_count = '0;
        req_requester_id = '0;
        req_tc = '0;
        req_wdata = '0;
        cpl_ready = 1'b1;
        ready_mode = 2'd0;
        stim_seed = SEED;
        ready_seed = SEED;
        next_tag = 4'd0;
        for (int b = 0; b < 4; b++)
        begin
            for (int g = 0; g < 8; g++)
            begin
                model[b][g] = 64'd0;
            end
        end
        for (int t = 0; t < 16; t++)
        begin
            slot_active[t] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Every register of every bank reads zero after reset
        check_value("zero_after_reset cpl_valid", 64'd0, 64'(cpl_valid));
        for (int i = 0; i < ZERO_READS; i++)
        begin
            take_free_tag(tag);
            draw_random(r);
            addr = '0;
            addr[9:8] = i[4:3];
            addr[5:3] = i[2:0];
            send_read(tag, addr, 4'd8, r[15:0], r[18:16], "zero_after_reset");
        end

        // Read issued in the cycle right after the write to the same register
        for (int i = 0; i < WR_RD_REQS / 2; i++)
        begin
            take_free_tag(tag);
            draw_random(r);
            wdata[63:32] = r;
            draw_random(r);
            wdata[31:0] = r;
            draw_random(r2);
            addr = '0;
            addr[9:8] = i[1:0];
            addr[5:3] = r2[26:24];
            send_write(addr, wdata);
            send_read(tag, addr, 4'd8, r2[15:0], r2[18:16], "write_then_read");
        end

        // Both 32-bit lanes, with bit 6 set in some addresses for lower_addr
        for (int i = 0; i < LANE_REQS / 3; i++)
        begin
            draw_random(r);
            wdata[63:32] = r;
            draw_random(r);
            wdata[31:0] = r;
            addr = '0;
            addr[9:8] = i[1:0];
            addr[6] = i[0];
            addr[5:3] = {i[1:0], 1'b1};
            send_write(addr, wdata);
            for (int j = 0; j < 2; j++)
            begin
                take_free_tag(tag);
                draw_random(r2);
                addr[2] = j[0];
                send_read(tag, addr, 4'd4, r2[15:0], r2[18:16], "lane_select");
            end
        end

        // All sixteen tags outstanding at once while the output is stalled
        wait_all_done();
        ready_mode = 2'd1;
        for (int i = 0; i < BURST_READS; i++)
        begin
            addr = '0;
            addr[9:8] = i[1:0];
            addr[5:3] = {1'b0, i[3:2]};
            send_read(i[3:0], addr, 4'd8, {12'hc00, i[3:0]}, i[2:0], "tag_burst");
        end
        idle_cycles(10);
        check_value("tag_burst stalled cpl_valid", 64'd1, 64'(cpl_valid));
        ready_mode = 2'd0;
        wait_all_done();

        // Long random mix under random back-pressure
        ready_mode = 2'd2;
        for (int i = 0; i < MIX_REQS; i++)
        begin
            draw_random(r);
            if (r[3:0] == 4'd0)
            begin
                idle_cycles(1);
            end
            addr = {r[9:8], r[11:10], r[14:12], r[15], 2'b00};
            if (r[5])
            begin
                draw_random(r2);
                wdata[63:32] = r2;
                draw_random(r2);
                wdata[31:0] = r2;
                send_write(addr, wdata);
            end
            else
            begin
                bcount = r[16] ? 4'd8 : 4'd4;
                if (bcount == 4'd8)
                begin
                    addr[2] = 1'b0;
                end
                take_free_tag(tag);
                draw_random(r2);
                send_read(tag, addr, bcount, r2[15:0], r2[18:16], "random_mix");
            end
        end
        ready_mode = 2'd0;
        wait_all_done();
        idle_cycles(4);
        check_value("final cpl_valid", 64'd0, 64'(cpl_valid));

        $display("Checks: %0d, value errors: %0d, other errors: %0d, completions: %0d",
                 checks, value_errors, other_errors, completions);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary -j 0
TOP = mmio_host_chan_tb
FLIST = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// File: flist.f
hdl/mmio_pkg.sv
hdl/mmio_req_decoder.sv
hdl/mmio_csr_bank.sv
hdl/mmio_rsp_arbiter.sv
hdl/mmio_cpl_gen.sv
hdl/mmio_host_chan.sv
verification/mmio_host_chan_tb.sv
